/* decode_cfg.svh */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Instructions per fetch packet, one decoder lane each
`define LANES 2

// Pc and immediate width
`define XLEN 32

// Instruction word width
`define ILEN 32

`endif

/* decode_pkg.sv */
`include "decode_cfg.svh"

package decode_pkg;

  // RV32I major opcodes, bits 6:0 of the instruction word
  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    MISC_MEM = 7'b0001111,
    SYSTEM   = 7'b1110011
  } opcode_e;

  // Execution class of a decoded instruction
  typedef enum logic [3:0] {
    CLS_NONE    = 4'd0,
    CLS_ALU     = 4'd1,
    CLS_BRANCH  = 4'd2,
    CLS_JUMP    = 4'd3,
    CLS_LOAD    = 4'd4,
    CLS_STORE   = 4'd5,
    CLS_FENCE   = 4'd6,
    CLS_SYSTEM  = 4'd7,
    CLS_ILLEGAL = 4'd8
  } op_class_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    op_class_e        op_class;
    alu_op_e          alu_op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic             wren;
    logic             rden1;
    logic             rden2;
    logic             exception;
  } decoded_instr_t;

endpackage

/* lane_if.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

// One lane of a fetch packet on its way to a decoder
interface lane_if;

  logic             valid;
  logic [`XLEN-1:0] pc;
  logic [`ILEN-1:0] instr;

  modport split (
    output valid,
    output pc,
    output instr
  );

  modport dec (
    input valid,
    input pc,
    input instr
  );

endinterface

/* fetch_lane_split.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

module fetch_lane_split (
  input  logic                    fetch_valid,
  input  logic [`XLEN-1:0]        fetch_pc,
  input  logic [`LANES*`ILEN-1:0] fetch_packet,
  lane_if.split                   lanes [`LANES]
);

  // Byte offset bits inside one packet
  localparam logic [`XLEN-1:0] PKT_MASK = `XLEN'(`LANES * 4 - 1);

  logic [`XLEN-1:0] base_pc;
  logic [`XLEN-1:0] word_offset;

  assign base_pc = fetch_pc & ~PKT_MASK;
  assign word_offset = (fetch_pc & PKT_MASK) >> 2;

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic lane_live;

    // Slots before a branch target in the packet are killed
    assign lane_live = fetch_valid && (`XLEN'(i) >= word_offset);

    assign lanes[i].valid = lane_live;
    assign lanes[i].pc = base_pc + `XLEN'(4 * i);
    assign lanes[i].instr = lane_live ? fetch_packet[i*`ILEN +: `ILEN] : '0;
  end

endmodule

/* rv32i_decoder.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

module rv32i_decoder (
  lane_if.dec                        lane,
  output decode_pkg::decoded_instr_t result
);

  import decode_pkg::*;

  logic [`ILEN-1:0] instr;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic             op_legal;

  // Shared funct3 map of OP and OP_IMM, alt selects SUB or SRA
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign instr = lane.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                  1'b0};

  // Only ADD/SUB and SRL/SRA have an alternate funct7
  assign op_legal = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    result = '0;
    result.op_class = CLS_NONE;
    result.alu_op = ADD;
    result.rd = instr[11:7];
    result.rs1 = instr[19:15];
    result.rs2 = instr[24:20];
    if (lane.valid) begin
      result.valid = 1'b1;
      result.pc = lane.pc;
      case (opcode_e'(instr[6:0]))
        LUI: begin
          result.op_class = CLS_ALU;
          result.alu_op = PASS_B;
          result.imm = imm_u;
          result.wren = 1'b1;
        end
        AUIPC: begin
          result.op_class = CLS_ALU;
          result.imm = imm_u;
          result.wren = 1'b1;
        end
        JAL: begin
          result.op_class = CLS_JUMP;
          result.imm = imm_j;
          result.wren = 1'b1;
        end
        JALR: begin
          result.op_class = CLS_JUMP;
          result.imm = imm_i;
          result.wren = 1'b1;
          result.rden1 = 1'b1;
        end
        BRANCH: begin
          result.op_class = CLS_BRANCH;
          result.imm = imm_b;
          result.rden1 = 1'b1;
          result.rden2 = 1'b1;
        end
        LOAD: begin
          result.op_class = CLS_LOAD;
          result.imm = imm_i;
          result.wren = 1'b1;
          result.rden1 = 1'b1;
        end
        STORE: begin
          result.op_class = CLS_STORE;
          result.imm = imm_s;
          result.rden1 = 1'b1;
          result.rden2 = 1'b1;
        end
        OP_IMM: begin
          result.op_class = CLS_ALU;
          result.alu_op = alu_from_funct(funct3, funct3 == 3'b101 && instr[30]);
          result.imm = imm_i;
          result.wren = 1'b1;
          result.rden1 = 1'b1;
        end
        OP: begin
          if (op_legal) begin
            result.op_class = CLS_ALU;
            result.alu_op = alu_from_funct(funct3, instr[30]);
            result.wren = 1'b1;
            result.rden1 = 1'b1;
            result.rden2 = 1'b1;
          end else begin
            result.op_class = CLS_ILLEGAL;
            result.exception = 1'b1;
          end
        end
        MISC_MEM: begin
          result.op_class = CLS_FENCE;
          result.imm = imm_i;
        end
        SYSTEM: begin
          result.op_class = CLS_SYSTEM;
          result.imm = imm_i;
        end
        default: begin
          result.op_class = CLS_ILLEGAL;
          result.exception = 1'b1;
        end
      endcase
      // x0 is never written
      if (result.rd == 5'd0) begin
        result.wren = 1'b0;
      end
    end
  end

endmodule

/* decode_register.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_register (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      in_valid,
  input  decode_pkg::decoded_instr_t lanes_in [`LANES],
  input  logic                      out_ready,
  output logic                      in_ready,
  output logic                      out_valid,
  output decode_pkg::decoded_instr_t lanes_out [`LANES]
);

  import decode_pkg::*;

  logic           full;
  logic           load;
  decoded_instr_t lanes_q [`LANES];

  // Accept when empty or when the held packet leaves this cycle
  assign in_ready = !full || out_ready;
  assign load = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (clear) begin
      // Flush wins over a packet arriving at the same edge
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      lanes_q <= lanes_in;
    end
  end

  assign out_valid = full;
  assign lanes_out = lanes_q;

endmodule

/* decode_stage_top.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    fetch_valid,
  input  logic [`XLEN-1:0]        fetch_pc,
  input  logic [`LANES*`ILEN-1:0] fetch_packet,
  output logic                    fetch_ready,
  input  logic                    out_ready,
  output logic                    out_valid,
  output logic                    dec_valid [`LANES],
  output logic [`XLEN-1:0]        dec_pc [`LANES],
  output decode_pkg::op_class_e   dec_class [`LANES],
  output decode_pkg::alu_op_e     dec_alu_op [`LANES],
  output logic [4:0]              dec_rd [`LANES],
  output logic [4:0]              dec_rs1 [`LANES],
  output logic [4:0]              dec_rs2 [`LANES],
  output logic [`XLEN-1:0]        dec_imm [`LANES],
  output logic                    dec_wren [`LANES],
  output logic                    dec_rden1 [`LANES],
  output logic                    dec_rden2 [`LANES],
  output logic                    dec_exception [`LANES]
);

  import decode_pkg::*;

  lane_if         lane_bus [`LANES] ();
  decoded_instr_t dec_lanes [`LANES];
  decoded_instr_t reg_lanes [`LANES];

  fetch_lane_split fetch_lane_split_inst (
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_packet (fetch_packet),
    .lanes        (lane_bus)
  );

  for (genvar i = 0; i < `LANES; i++) begin : g_dec
    rv32i_decoder rv32i_decoder_inst (
      .lane   (lane_bus[i]),
      .result (dec_lanes[i])
    );
  end

  decode_register decode_register_inst (
    .clock     (clock),
    .reset     (reset),
    .clear     (clear),
    .in_valid  (fetch_valid),
    .lanes_in  (dec_lanes),
    .out_ready (out_ready),
    .in_ready  (fetch_ready),
    .out_valid (out_valid),
    .lanes_out (reg_lanes)
  );

  // Registered struct fields onto the plain output arrays
  for (genvar i = 0; i < `LANES; i++) begin : g_out
    assign dec_valid[i] = reg_lanes[i].valid;
    assign dec_pc[i] = reg_lanes[i].pc;
    assign dec_class[i] = reg_lanes[i].op_class;
    assign dec_alu_op[i] = reg_lanes[i].alu_op;
    assign dec_rd[i] = reg_lanes[i].rd;
    assign dec_rs1[i] = reg_lanes[i].rs1;
    assign dec_rs2[i] = reg_lanes[i].rs2;
    assign dec_imm[i] = reg_lanes[i].imm;
    assign dec_wren[i] = reg_lanes[i].wren;
    assign dec_rden1[i] = reg_lanes[i].rden1;
    assign dec_rden2[i] = reg_lanes[i].rden2;
    assign dec_exception[i] = reg_lanes[i].exception;
  end

endmodule

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`include "decode_cfg.svh"

module tb_decode_stage;

  import decode_pkg::*;

  localparam int WAIT_LIMIT = 50;

  logic                    clock;
  logic                    reset;
  logic                    clear;
  logic                    fetch_valid;
  logic [`XLEN-1:0]        fetch_pc;
  logic [`LANES*`ILEN-1:0] fetch_packet;
  logic                    fetch_ready;
  logic                    out_ready;
  logic                    out_valid;
  logic                    dec_valid [`LANES];
  logic [`XLEN-1:0]        dec_pc [`LANES];
  op_class_e               dec_class [`LANES];
  alu_op_e                 dec_alu_op [`LANES];
  logic [4:0]              dec_rd [`LANES];
  logic [4:0]              dec_rs1 [`LANES];
  logic [4:0]              dec_rs2 [`LANES];
  logic [`XLEN-1:0]        dec_imm [`LANES];
  logic                    dec_wren [`LANES];
  logic                    dec_rden1 [`LANES];
  logic                    dec_rden2 [`LANES];
  logic                    dec_exception [`LANES];

  // Expected values of the current test
  op_class_e               exp_class [`LANES];
  alu_op_e                 exp_alu [`LANES];
  logic [4:0]              exp_rd [`LANES];
  logic [4:0]              exp_rs1 [`LANES];
  logic [4:0]              exp_rs2 [`LANES];
  logic [`XLEN-1:0]        exp_imm [`LANES];
  logic                    exp_exc [`LANES];
  logic                    exp_valid [`LANES];
  logic [`ILEN-1:0]        exp_word [`LANES];
  logic [`XLEN-1:0]        exp_base;

  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  bit test_bad;
  bit hung = 1'b0;

  decode_stage_top decode_stage_top_inst (
    .clock (clock), .reset (reset), .clear (clear),
    .fetch_valid (fetch_valid), .fetch_pc (fetch_pc), .fetch_packet (fetch_packet),
    .fetch_ready (fetch_ready), .out_ready (out_ready), .out_valid (out_valid),
    .dec_valid (dec_valid), .dec_pc (dec_pc), .dec_class (dec_class),
    .dec_alu_op (dec_alu_op), .dec_rd (dec_rd), .dec_rs1 (dec_rs1), .dec_rs2 (dec_rs2),
    .dec_imm (dec_imm), .dec_wren (dec_wren), .dec_rden1 (dec_rden1),
    .dec_rden2 (dec_rden2), .dec_exception (dec_exception)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic op_class_e parse_class(input string s);
    case (s)
      "ALU":     return CLS_ALU;
      "BRANCH":  return CLS_BRANCH;
      "JUMP":    return CLS_JUMP;
      "LOAD":    return CLS_LOAD;
      "STORE":   return CLS_STORE;
      "FENCE":   return CLS_FENCE;
      "SYSTEM":  return CLS_SYSTEM;
      "ILLEGAL": return CLS_ILLEGAL;
      default:   return CLS_NONE;
    endcase
  endfunction

  function automatic alu_op_e parse_alu(input string s);
    case (s)
      "SUB":    return SUB;
      "SLL":    return SLL;
      "SLT":    return SLT;
      "SLTU":   return SLTU;
      "XOR":    return XOR;
      "SRL":    return SRL;
      "SRA":    return SRA;
      "OR":     return OR;
      "AND":    return AND;
      "PASS_B": return PASS_B;
      default:  return ADD;
    endcase
  endfunction

  // Source registers read by the R, S and B formats and the register I formats
  function automatic logic [1:0] source_reads(input logic [6:0] opc, input op_class_e cls);
    logic [1:0] reads;
    case (opcode_e'(opc))
      OP, STORE, BRANCH:  reads = 2'b11;
      OP_IMM, LOAD, JALR: reads = 2'b10;
      default:            reads = 2'b00;
    endcase
    if (cls == CLS_ILLEGAL) begin
      reads = 2'b00;
    end
    return reads;
  endfunction

  task automatic note_error();
    errors++;
    test_bad = 1'b1;
  endtask

  task automatic check_class(input string what, input op_class_e exp, input op_class_e act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %s actual %s", what, exp.name(), act.name());
      note_error();
    end
  endtask

  task automatic check_alu_op(input string what, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %s actual %s", what, exp.name(), act.name());
      note_error();
    end
  endtask

  task automatic check_word(input string what, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", what, exp, act);
      note_error();
    end
  endtask

  task automatic check_reg(input string what, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %0d actual %0d", what, exp, act);
      note_error();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %b actual %b", what, exp, act);
      note_error();
    end
  endtask

  task automatic give_up(input string why);
    $display("Timeout: %s", why);
    errors++;
    hung = 1'b1;
  endtask

  // Compare every lane on the output side against the expected decode
  task automatic compare_lanes(input string name);
    string      tag;
    logic       wr;
    logic [1:0] reads;
    for (int i = 0; i < `LANES; i++) begin
      tag = $sformatf("%s lane%0d", name, i);
      check_flag({tag, " valid"}, exp_valid[i], dec_valid[i]);
      if (exp_valid[i]) begin
        wr = (exp_rd[i] != 5'd0) &&
             (exp_class[i] == CLS_ALU || exp_class[i] == CLS_JUMP || exp_class[i] == CLS_LOAD);
        reads = source_reads(exp_word[i][6:0], exp_class[i]);
        check_word({tag, " pc"}, exp_base + 4 * i, dec_pc[i]);
        check_class({tag, " class"}, exp_class[i], dec_class[i]);
        check_alu_op({tag, " alu_op"}, exp_alu[i], dec_alu_op[i]);
        check_reg({tag, " rd"}, exp_rd[i], dec_rd[i]);
        check_reg({tag, " rs1"}, exp_rs1[i], dec_rs1[i]);
        check_reg({tag, " rs2"}, exp_rs2[i], dec_rs2[i]);
        check_word({tag, " imm"}, exp_imm[i], dec_imm[i]);
        check_flag({tag, " exception"}, exp_exc[i], dec_exception[i]);
        check_flag({tag, " wren"}, wr, dec_wren[i]);
        check_flag({tag, " rden1"}, reads[1], dec_rden1[i]);
        check_flag({tag, " rden2"}, reads[0], dec_rden2[i]);
      end
    end
  endtask

  task automatic run_test(input string name, input logic [`XLEN-1:0] pc,
                          input logic [`LANES*`ILEN-1:0] packet, input logic clr, input int stall);
    int n;
    n = 0;
    test_bad = 1'b0;
    exp_base = pc - pc % (`LANES * 4);
    for (int i = 0; i < `LANES; i++) begin
      exp_word[i] = packet[i*`ILEN +: `ILEN];
    end
    @(posedge clock);
    fetch_valid <= 1'b1;
    fetch_pc <= pc;
    fetch_packet <= packet;
    clear <= clr;
    out_ready <= (stall == 0);
    @(negedge clock);
    while (!fetch_ready) begin
      if (++n > WAIT_LIMIT) begin
        give_up({name, ": fetch_ready never went high"});
        return;
      end
      @(negedge clock);
    end
    @(posedge clock);
    fetch_valid <= 1'b0;
    clear <= 1'b0;
    @(negedge clock);
    if (clr) begin
      check_flag({name, " out_valid after flush"}, 1'b0, out_valid);
    end else begin
      n = 0;
      while (!out_valid) begin
        if (++n > WAIT_LIMIT) begin
          give_up({name, ": out_valid never went high"});
          return;
        end
        @(negedge clock);
      end
      compare_lanes(name);
      if (stall > 0) begin
        // Next packet waits on the fetch side while the result is held
        @(posedge clock);
        fetch_valid <= 1'b1;
        fetch_pc <= pc + `XLEN'(`LANES * 4);
        for (int k = 0; k < stall; k++) begin
          @(negedge clock);
          check_flag({name, " out_valid while held"}, 1'b1, out_valid);
          check_flag({name, " fetch_ready while held"}, 1'b0, fetch_ready);
          compare_lanes(name);
        end
        @(posedge clock);
        out_ready <= 1'b1;
        @(negedge clock);
        compare_lanes(name);
        @(posedge clock);
        fetch_valid <= 1'b0;
        @(negedge clock);
        exp_base = exp_base + `XLEN'(`LANES * 4);
        check_flag({name, " out_valid of next packet"}, 1'b1, out_valid);
        compare_lanes({name, " next"});
      end
    end
    tests_run++;
    if (test_bad) begin
      tests_bad++;
      $display("test %s failed", name);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  initial begin
    int fd;
    int n;
    string line;
    string name;
    string c0;
    string a0;
    string c1;
    string a1;
    logic [`XLEN-1:0] pc;
    logic [`ILEN-1:0] w0;
    logic [`ILEN-1:0] w1;
    int clr;
    int stall;
    reset = 1'b0;
    clear = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_packet = '0;
    out_ready = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_flag("reset out_valid", 1'b0, out_valid);
    check_flag("reset fetch_ready", 1'b1, fetch_ready);
    fd = $fopen("decode_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file decode_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !hung) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %h %h %h %d %d %s %s %h %h %h %h %h %h %s %s %h %h %h %h %h %h",
                    name, pc, w0, w1, clr, stall,
                    c0, a0, exp_rd[0], exp_rs1[0], exp_rs2[0], exp_imm[0], exp_exc[0],
                    exp_valid[0],
                    c1, a1, exp_rd[1], exp_rs1[1], exp_rs2[1], exp_imm[1], exp_exc[1],
                    exp_valid[1]);
        if (n != 22) begin
          $display("Trace line could not be read: %s", line);
          errors++;
          continue;
        end
        exp_class[0] = parse_class(c0);
        exp_alu[0] = parse_alu(a0);
        exp_class[1] = parse_class(c1);
        exp_alu[1] = parse_alu(a1);
        run_test(name, pc, {w1, w0}, clr[0], stall);
      end
      $fclose(fd);
    end
    $display("tests %0d, failed tests %0d, check errors %0d", tests_run, tests_bad, errors);
    if (errors == 0 && tests_run > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
decode_pkg.sv
lane_if.sv
fetch_lane_split.sv
rv32i_decoder.sv
decode_register.sv
decode_stage_top.sv
tb_decode_stage.sv

/* decode_trace.txt */
# name pc word0 word1 clear stall, then per lane: class alu rd rs1 rs2 imm exception valid
# Stall is the number of cycles out_ready stays low once the result is visible
imm_i_s 00001000 ffb10093 fe532c23 0 0 ALU ADD 01 02 1b fffffffb 0 1 STORE ADD 18 06 05 fffffff8 0 1
imm_b_u 00001008 fe2088e3 800001b7 0 0 BRANCH ADD 11 01 02 fffffff0 0 1 ALU PASS_B 03 00 00 80000000 0 1
imm_j 00001010 ffdff0ef 12345217 0 0 JUMP ADD 01 1f 1d fffffffc 0 1 ALU ADD 04 08 03 12345000 0 1
op_sub_srai 00001018 409403b3 40355013 0 0 ALU SUB 07 08 09 00000000 0 1 ALU SRA 00 0a 03 00000403 0 1
op_sltu_xori 00001020 00d635b3 fff7c713 0 0 ALU SLTU 0b 0c 0d 00000000 0 1 ALU XOR 0e 0f 1f ffffffff 0 1
offset_one 0000102c 00000013 00100293 0 0 NONE ADD 00 00 00 00000000 0 0 ALU ADD 05 00 01 00000001 0 1
bad_opcode 00001030 0000007f 003100b3 0 0 ILLEGAL ADD 00 00 00 00000000 1 1 ALU ADD 01 02 03 00000000 0 1
bad_funct7 00001038 023100b3 00000013 0 0 ILLEGAL ADD 01 02 03 00000000 1 1 ALU ADD 00 00 00 00000000 0 1
held_output 00001040 00c3a303 008480a3 0 4 LOAD ADD 06 07 0c 0000000c 0 1 STORE ADD 01 09 08 00000001 0 1
after_hold 00001048 0ff0000f 00000073 0 0 FENCE ADD 00 00 1f 000000ff 0 1 SYSTEM ADD 00 00 00 00000000 0 1
flushed 00001050 00100093 00200113 1 0 ALU ADD 01 00 01 00000001 0 1 ALU ADD 02 00 02 00000002 0 1
after_flush 00001050 00100093 00200113 0 0 ALU ADD 01 00 01 00000001 0 1 ALU ADD 02 00 02 00000002 0 1
